// ==== Makefile ====
# Verilator flow for the data cache storage testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache_mem
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the log
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
verilog/dcache_pkg.sv
verilog/flush_fsm.sv
verilog/victim_select.sv
verilog/tag_array.sv
verilog/data_array.sv
verilog/dcache_mem_top.sv
tests/dcache_mem_props.sv
tests/tb_dcache_mem.sv

// ==== tests/dcache_mem_props.sv ====
`default_nettype none

module dcache_mem_props #(
  parameter int unsigned NUM_WAYS = 4
) (
  input wire logic                clk_i,
  input wire logic                rst_ni,
  input wire logic [NUM_WAYS-1:0] way_hit_i,
  input wire logic                flushing_i,
  input wire logic                flush_ack_i
);

  // Lookup matches at most one way
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(way_hit_i))
    else $error("way_hit has more than one way set");

  // Acknowledge is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_ack_i |=> !flush_ack_i)
    else $error("flush_ack_o stayed high for two cycles");

  // Acknowledge comes right after the last sweep cycle, never during it
  ack_after_sweep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_ack_i |-> !flushing_i && $past(flushing_i))
    else $error("flush_ack_o not directly after the sweep or overlapping it");

endmodule

bind dcache_mem_top dcache_mem_props #(
  .NUM_WAYS    (NUM_WAYS)
) i_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .way_hit_i   (way_hit),
  .flushing_i  (flushing),
  .flush_ack_i (flush_ack_o)
);

`default_nettype wire

// ==== tests/tb_dcache_mem.sv ====
`default_nettype none

module tb_dcache_mem import dcache_pkg::*; ();

  localparam int unsigned NUM_SETS      = DEF_NUM_SETS;
  localparam int unsigned NUM_WAYS      = DEF_NUM_WAYS;
  localparam int unsigned IDX_W         = $clog2(NUM_SETS);
  localparam int unsigned PTR_W         = $clog2(NUM_WAYS);
  // Generous bound on the flush sweep
  localparam int unsigned FLUSH_TIMEOUT = 4 * NUM_SETS;
  // Set used for the full-set miss sequence
  localparam logic [IDX_W-1:0] FULL_SET = IDX_W'(5);

  logic                clk_i;
  logic                rst_ni;
  logic                flush_i;
  logic                flush_ack_o;
  logic                rd_req_i;
  logic [IDX_W-1:0]    rd_idx_i;
  logic [TAG_W-1:0]    rd_tag_i;
  logic [OFF_W-1:0]    rd_off_i;
  logic                rd_ack_o;
  logic [NUM_WAYS-1:0] rd_hit_oh_o;
  logic [NUM_WAYS-1:0] rd_vld_bits_o;
  logic [WORD_W-1:0]   rd_data_o;
  logic [NUM_WAYS-1:0] victim_oh_o;
  logic                wr_cl_vld_i;
  logic [NUM_WAYS-1:0] wr_cl_we_i;
  logic [IDX_W-1:0]    wr_cl_idx_i;
  logic [TAG_W-1:0]    wr_cl_tag_i;
  logic [LINE_W-1:0]   wr_cl_data_i;
  logic [NUM_WAYS-1:0] wr_vld_bits_i;
  logic [NUM_WAYS-1:0] wr_req_i;
  logic [IDX_W-1:0]    wr_idx_i;
  logic [OFF_W-1:0]    wr_off_i;
  logic [WORD_W-1:0]   wr_data_i;
  logic                wr_ack_o;

  // Reference model of the cache contents
  logic [TAG_W-1:0]    m_tag  [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] m_vld  [NUM_SETS];
  logic [LINE_W-1:0]   m_data [NUM_SETS][NUM_WAYS];
  logic [PTR_W-1:0]    m_ptr;
  integer              seed;

  // Ports share their names with the testbench signals
  dcache_mem_top uut (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Model
  ////////////////////////////////////////////////////////////

  function automatic logic [NUM_WAYS-1:0] model_hit();
    logic [NUM_WAYS-1:0] hit;
    hit = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit[w] = m_vld[rd_idx_i][w] && (m_tag[rd_idx_i][w] == rd_tag_i);
    end
    return hit;
  endfunction

  // Scan downward so the lowest invalid way is the last one kept
  function automatic logic [NUM_WAYS-1:0] model_victim();
    logic [NUM_WAYS-1:0] vic;
    vic = NUM_WAYS'(1) << m_ptr;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!m_vld[rd_idx_i][w]) begin
        vic = NUM_WAYS'(1) << w;
      end
    end
    return vic;
  endfunction

  function automatic logic [WORD_W-1:0] model_word(input logic [NUM_WAYS-1:0] hit);
    logic [WORD_W-1:0] word;
    word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit[w]) begin
        word = m_data[rd_idx_i][w][rd_off_i*WORD_W +: WORD_W];
      end
    end
    return word;
  endfunction

  // Contents only, the pointer survives a flush
  task automatic clear_model();
    for (int s = 0; s < NUM_SETS; s++) begin
      m_vld[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w]  = '0;
        m_data[s][w] = '0;
      end
    end
  endtask

  task automatic update_model();
    // Pointer moves on the state before this edge
    if (rd_req_i && (&m_vld[rd_idx_i]) && (model_hit() == '0)) begin
      m_ptr = m_ptr + 1'b1;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_cl_vld_i && wr_cl_we_i[w]) begin
        m_tag[wr_cl_idx_i][w]  = wr_cl_tag_i;
        m_vld[wr_cl_idx_i][w]  = wr_vld_bits_i[w];
        m_data[wr_cl_idx_i][w] = wr_cl_data_i;
      end
    end
    // Word write second, it wins over a line write to the same way
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_req_i[w]) begin
        m_vld[wr_idx_i][w] = 1'b1;
        m_data[wr_idx_i][w][wr_off_i*WORD_W +: WORD_W] = wr_data_i;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [LINE_W-1:0] exp_v,
                           input logic [LINE_W-1:0] act_v);
    assert (act_v === exp_v) else begin
      $display("ERROR time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, exp_v, act_v);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    logic [NUM_WAYS-1:0] hit;
    hit = model_hit();
    check_val("rd_ack_o", LINE_W'(rd_req_i), LINE_W'(rd_ack_o));
    check_val("wr_ack_o", LINE_W'(|wr_req_i), LINE_W'(wr_ack_o));
    check_val("rd_hit_oh_o", LINE_W'(hit), LINE_W'(rd_hit_oh_o));
    check_val("rd_vld_bits_o", LINE_W'(m_vld[rd_idx_i]), LINE_W'(rd_vld_bits_o));
    check_val("rd_data_o", LINE_W'(model_word(hit)), LINE_W'(rd_data_o));
    check_val("victim_oh_o", LINE_W'(model_victim()), LINE_W'(victim_oh_o));
    check_val("flush_ack_o", '0, LINE_W'(flush_ack_o));
  endtask

  // Outputs are compared mid-cycle, then the model takes the coming edge
  task automatic check_cycle();
    @(negedge clk_i);
    check_outputs();
    update_model();
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_idle();
    flush_i       <= 1'b0;
    rd_req_i      <= 1'b0;
    rd_idx_i      <= '0;
    rd_tag_i      <= '0;
    rd_off_i      <= '0;
    wr_cl_vld_i   <= 1'b0;
    wr_cl_we_i    <= '0;
    wr_cl_idx_i   <= '0;
    wr_cl_tag_i   <= '0;
    wr_cl_data_i  <= '0;
    wr_vld_bits_i <= '0;
    wr_req_i      <= '0;
    wr_idx_i      <= '0;
    wr_off_i      <= '0;
    wr_data_i     <= '0;
  endtask

  task automatic drive_random(input logic with_writes);
    logic [31:0]      r;
    logic [31:0]      q;
    logic [PTR_W-1:0] cl_way;
    logic [PTR_W-1:0] wd_way;
    logic [IDX_W-1:0] cl_idx;
    logic [IDX_W-1:0] wd_idx;
    logic             same_line;
    r         = $random(seed);
    q         = $random(seed);
    cl_way    = r[13 +: PTR_W];
    cl_idx    = r[16 +: IDX_W];
    // One word write in four lands on the line write's set and way
    same_line = (q[3:2] == 2'b00);
    wd_way    = same_line ? cl_way : q[0 +: PTR_W];
    wd_idx    = same_line ? cl_idx : q[4 +: IDX_W];
    rd_req_i      <= r[0] | r[1];
    rd_idx_i      <= r[2 +: IDX_W];
    // Tags 0..7 only, hits are frequent
    rd_tag_i      <= TAG_W'(r[6 +: 3]);
    rd_off_i      <= r[9 +: OFF_W];
    wr_cl_vld_i   <= with_writes & r[11];
    wr_cl_we_i    <= NUM_WAYS'(1) << cl_way;
    wr_cl_idx_i   <= cl_idx;
    // Low tag bits hold the way number, no two ways of a set share a tag
    wr_cl_tag_i   <= TAG_W'({r[15], cl_way});
    wr_vld_bits_i <= r[20 +: NUM_WAYS] | r[24 +: NUM_WAYS];
    wr_cl_data_i  <= LINE_W'({$random(seed), $random(seed), $random(seed), $random(seed)});
    wr_idx_i      <= wd_idx;
    wr_off_i      <= q[8 +: OFF_W];
    wr_data_i     <= $random(seed);
    // Word writes only into ways whose tag already follows that rule
    if (with_writes && q[10] &&
        ((m_tag[wd_idx][wd_way][PTR_W-1:0] == wd_way) || (same_line && r[11]))) begin
      wr_req_i <= NUM_WAYS'(1) << wd_way;
    end else begin
      wr_req_i <= '0;
    end
  endtask

  task automatic run_flush();
    int   edges;
    logic ack_seen;
    edges    = 0;
    ack_seen = 1'b0;
    @(posedge clk_i);
    drive_idle();
    flush_i <= 1'b1;
    // Writes during the sweep must be dropped, flush_i held high is ignored
    while (!ack_seen && edges < FLUSH_TIMEOUT) begin
      @(posedge clk_i);
      edges++;
      drive_random(edges <= NUM_SETS);
      rd_req_i <= 1'b0;
      flush_i  <= (edges < NUM_SETS);
      @(negedge clk_i);
      ack_seen = flush_ack_o;
    end
    if (!ack_seen) begin
      $display("ERROR flush_ack_o never rose within %0d cycles of the flush request",
               FLUSH_TIMEOUT);
      $display("TESTBENCH FAILED");
      $fatal(1, "flush timeout");
    end
    check_val("flush_ack_o delay", LINE_W'(NUM_SETS + 1), LINE_W'(edges));
    // Sweep is done, everything reads as empty
    @(posedge clk_i);
    drive_idle();
    clear_model();
    check_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed   = 32'hcbbd_fa15;
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    drive_idle();
    clear_model();
    m_ptr = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Empty cache, every read misses
    repeat (20) begin
      @(posedge clk_i);
      drive_random(1'b0);
      check_cycle();
    end

    repeat (400) begin
      @(posedge clk_i);
      drive_random(1'b1);
      check_cycle();
    end

    // Fill one set way by way, then miss on it repeatedly
    for (int w = 0; w < NUM_WAYS; w++) begin
      @(posedge clk_i);
      drive_idle();
      wr_cl_vld_i   <= 1'b1;
      wr_cl_we_i    <= NUM_WAYS'(1) << w;
      wr_cl_idx_i   <= FULL_SET;
      wr_cl_tag_i   <= TAG_W'(8'h80 + w);
      wr_vld_bits_i <= '1;
      wr_cl_data_i  <= LINE_W'({4{$random(seed)}});
      check_cycle();
    end
    repeat (2 * NUM_WAYS + 1) begin
      @(posedge clk_i);
      drive_idle();
      rd_req_i <= 1'b1;
      rd_idx_i <= FULL_SET;
      rd_tag_i <= 8'hff;
      check_cycle();
    end

    run_flush();

    repeat (40) begin
      @(posedge clk_i);
      drive_random(1'b0);
      check_cycle();
    end

    repeat (150) begin
      @(posedge clk_i);
      drive_random(1'b1);
      check_cycle();
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/data_array.sv ====
`default_nettype none

module data_array import dcache_pkg::*; #(
  parameter int unsigned  NUM_SETS = DEF_NUM_SETS,
  parameter int unsigned  NUM_WAYS = DEF_NUM_WAYS,
  localparam int unsigned IDX_W    = $clog2(NUM_SETS)
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Flush sweep
  input  wire logic                flushing_i,
  input  wire logic [IDX_W-1:0]    flush_idx_i,
  // Line write
  input  wire logic                wr_cl_vld_i,
  input  wire logic [NUM_WAYS-1:0] wr_cl_we_i,
  input  wire logic [IDX_W-1:0]    wr_cl_idx_i,
  input  wire logic [LINE_W-1:0]   wr_cl_data_i,
  // Word write
  input  wire logic [NUM_WAYS-1:0] wr_req_i,
  input  wire logic [IDX_W-1:0]    wr_idx_i,
  input  wire logic [OFF_W-1:0]    wr_off_i,
  input  wire logic [WORD_W-1:0]   wr_data_i,
  // Read side
  input  wire logic [IDX_W-1:0]    rd_idx_i,
  input  wire logic [OFF_W-1:0]    rd_off_i,
  input  wire logic [NUM_WAYS-1:0] way_hit_i,
  output logic [WORD_W-1:0]        rd_data_o
);

  logic [LINE_W-1:0] data_q [NUM_SETS][NUM_WAYS];
  logic [LINE_W-1:0] hit_line;

  ////////////////////////////////////////////////////////////
  // Line and word writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          data_q[s][w] <= '0;
        end
      end
    end else if (flushing_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        data_q[flush_idx_i][w] <= '0;
      end
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (wr_cl_vld_i && wr_cl_we_i[w]) begin
          data_q[wr_cl_idx_i][w] <= wr_cl_data_i;
        end
        // Later assignment, so the word beats the line
        if (wr_req_i[w]) begin
          data_q[wr_idx_i][w][wr_off_i*WORD_W +: WORD_W] <= wr_data_i;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Hit way readout
  ////////////////////////////////////////////////////////////

  // AND-OR mux, hit is one-hot so at most one line passes
  // A miss leaves the line at zero
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit_i[w]) begin
        hit_line = hit_line | data_q[rd_idx_i][w];
      end
    end
  end

  assign rd_data_o = hit_line[rd_off_i*WORD_W +: WORD_W];

endmodule

`default_nettype wire

// ==== verilog/dcache_mem_top.sv ====
`default_nettype none

module dcache_mem_top import dcache_pkg::*; #(
  parameter int unsigned  NUM_SETS = DEF_NUM_SETS,
  parameter int unsigned  NUM_WAYS = DEF_NUM_WAYS,
  localparam int unsigned IDX_W    = $clog2(NUM_SETS)
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  // Flush
  input  wire logic                flush_i,
  output logic                     flush_ack_o,

  // Lookup port
  input  wire logic                rd_req_i,
  input  wire logic [IDX_W-1:0]    rd_idx_i,
  input  wire logic [TAG_W-1:0]    rd_tag_i,
  input  wire logic [OFF_W-1:0]    rd_off_i,
  output logic                     rd_ack_o,
  output logic [NUM_WAYS-1:0]      rd_hit_oh_o,
  output logic [NUM_WAYS-1:0]      rd_vld_bits_o,
  output logic [WORD_W-1:0]        rd_data_o,
  // Refill way suggestion for the addressed set
  output logic [NUM_WAYS-1:0]      victim_oh_o,

  // Cache line write
  input  wire logic                wr_cl_vld_i,
  input  wire logic [NUM_WAYS-1:0] wr_cl_we_i,
  input  wire logic [IDX_W-1:0]    wr_cl_idx_i,
  input  wire logic [TAG_W-1:0]    wr_cl_tag_i,
  input  wire logic [LINE_W-1:0]   wr_cl_data_i,
  input  wire logic [NUM_WAYS-1:0] wr_vld_bits_i,

  // Single word write, wr_req_i is the way mask
  input  wire logic [NUM_WAYS-1:0] wr_req_i,
  input  wire logic [IDX_W-1:0]    wr_idx_i,
  input  wire logic [OFF_W-1:0]    wr_off_i,
  input  wire logic [WORD_W-1:0]   wr_data_i,
  output logic                     wr_ack_o
);

  logic                flushing;
  logic [IDX_W-1:0]    flush_idx;
  logic [NUM_WAYS-1:0] way_valid;
  logic [NUM_WAYS-1:0] way_hit;

  ////////////////////////////////////////////////////////////
  // Flush sequencer
  ////////////////////////////////////////////////////////////

  flush_fsm #(
    .NUM_SETS    (NUM_SETS)
  ) i_flush_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .flushing_o  (flushing),
    .flush_idx_o (flush_idx),
    .flush_ack_o (flush_ack_o)
  );

  ////////////////////////////////////////////////////////////
  // Storage and lookup
  ////////////////////////////////////////////////////////////

  tag_array #(
    .NUM_SETS      (NUM_SETS),
    .NUM_WAYS      (NUM_WAYS)
  ) i_tag_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flushing_i    (flushing),
    .flush_idx_i   (flush_idx),
    .rd_idx_i      (rd_idx_i),
    .rd_tag_i      (rd_tag_i),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_tag_i   (wr_cl_tag_i),
    .wr_vld_bits_i (wr_vld_bits_i),
    .wr_req_i      (wr_req_i),
    .wr_idx_i      (wr_idx_i),
    .way_valid_o   (way_valid),
    .way_hit_o     (way_hit)
  );

  data_array #(
    .NUM_SETS     (NUM_SETS),
    .NUM_WAYS     (NUM_WAYS)
  ) i_data_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flushing_i   (flushing),
    .flush_idx_i  (flush_idx),
    .wr_cl_vld_i  (wr_cl_vld_i),
    .wr_cl_we_i   (wr_cl_we_i),
    .wr_cl_idx_i  (wr_cl_idx_i),
    .wr_cl_data_i (wr_cl_data_i),
    .wr_req_i     (wr_req_i),
    .wr_idx_i     (wr_idx_i),
    .wr_off_i     (wr_off_i),
    .wr_data_i    (wr_data_i),
    .rd_idx_i     (rd_idx_i),
    .rd_off_i     (rd_off_i),
    .way_hit_i    (way_hit),
    .rd_data_o    (rd_data_o)
  );

  // Replacement
  victim_select #(
    .NUM_WAYS    (NUM_WAYS)
  ) i_victim_select (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req_i),
    .way_valid_i (way_valid),
    .way_hit_i   (way_hit),
    .victim_oh_o (victim_oh_o)
  );

  // Lookup results straight from the tag array
  assign rd_hit_oh_o   = way_hit;
  assign rd_vld_bits_o = way_valid;

  // Same-cycle acknowledge echoes
  assign rd_ack_o = rd_req_i;
  assign wr_ack_o = |wr_req_i;

endmodule

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

  ////////////////////////////////////////////////////////////
  // Default geometry
  ////////////////////////////////////////////////////////////

  // Number of sets, power of two
  localparam int unsigned DEF_NUM_SETS = 16;
  // Associativity, power of two
  localparam int unsigned DEF_NUM_WAYS = 4;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  // Stored tag bits per way
  localparam int unsigned TAG_W = 8;
  // One data word
  localparam int unsigned WORD_W = 32;
  // Words held in one cache line
  localparam int unsigned WORDS_PER_LINE = 4;
  // Word offset inside a line
  localparam int unsigned OFF_W = $clog2(WORDS_PER_LINE);
  // Full line, 128 bits with the defaults above
  localparam int unsigned LINE_W = WORD_W * WORDS_PER_LINE;

  ////////////////////////////////////////////////////////////
  // Flush sequencer states
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // Waiting for a flush request
    FLUSH_IDLE  = 2'd0,
    // Clearing one set per cycle
    FLUSH_SWEEP = 2'd1,
    // One-cycle acknowledge
    FLUSH_ACK   = 2'd2
  } flush_state_e;

endpackage

`default_nettype wire

// ==== verilog/flush_fsm.sv ====
`default_nettype none

module flush_fsm import dcache_pkg::*; #(
  parameter int unsigned  NUM_SETS = DEF_NUM_SETS,
  localparam int unsigned IDX_W    = $clog2(NUM_SETS)
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  // Flush request, only seen in FLUSH_IDLE
  input  wire logic             flush_i,
  // High while the sweep is running
  output logic                  flushing_o,
  // Set cleared in the current sweep cycle
  output logic [IDX_W-1:0]      flush_idx_o,
  // Single-cycle pulse once every set is cleared
  output logic                  flush_ack_o
);

  // Last set of the sweep
  localparam logic [IDX_W-1:0] LAST_SET = IDX_W'(NUM_SETS - 1);

  flush_state_e     state_q, state_d;
  logic [IDX_W-1:0] cnt_q, cnt_d;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;

    case (state_q)
      FLUSH_IDLE: begin
        // Start sweeping from set 0 on the next cycle
        if (flush_i) begin
          state_d = FLUSH_SWEEP;
          cnt_d   = '0;
        end
      end
      FLUSH_SWEEP: begin
        // Counter wraps back to 0 after the last set
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == LAST_SET) begin
          state_d = FLUSH_ACK;
        end
      end
      FLUSH_ACK: begin
        state_d = FLUSH_IDLE;
      end
      default: begin
        state_d = FLUSH_IDLE;
      end
    endcase
  end

  // State and set counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FLUSH_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Outputs decoded from the registered state
  assign flushing_o  = (state_q == FLUSH_SWEEP);
  assign flush_idx_o = cnt_q;
  assign flush_ack_o = (state_q == FLUSH_ACK);

endmodule

`default_nettype wire

// ==== verilog/tag_array.sv ====
`default_nettype none

module tag_array import dcache_pkg::*; #(
  parameter int unsigned  NUM_SETS = DEF_NUM_SETS,
  parameter int unsigned  NUM_WAYS = DEF_NUM_WAYS,
  localparam int unsigned IDX_W    = $clog2(NUM_SETS)
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Flush sweep
  input  wire logic                flushing_i,
  input  wire logic [IDX_W-1:0]    flush_idx_i,
  // Lookup address
  input  wire logic [IDX_W-1:0]    rd_idx_i,
  input  wire logic [TAG_W-1:0]    rd_tag_i,
  // Line write, tag and valid part
  input  wire logic                wr_cl_vld_i,
  input  wire logic [NUM_WAYS-1:0] wr_cl_we_i,
  input  wire logic [IDX_W-1:0]    wr_cl_idx_i,
  input  wire logic [TAG_W-1:0]    wr_cl_tag_i,
  input  wire logic [NUM_WAYS-1:0] wr_vld_bits_i,
  // Word write way mask and set
  input  wire logic [NUM_WAYS-1:0] wr_req_i,
  input  wire logic [IDX_W-1:0]    wr_idx_i,
  // Lookup results
  output logic [NUM_WAYS-1:0]      way_valid_o,
  output logic [NUM_WAYS-1:0]      way_hit_o
);

  // Tag and valid storage, one valid vector per set
  logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];

  ////////////////////////////////////////////////////////////
  // Update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
          tag_q[s][w] <= '0;
        end
      end
    end else if (flushing_i) begin
      // Sweep clears one whole set, writes are dropped
      valid_q[flush_idx_i] <= '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        tag_q[flush_idx_i][w] <= '0;
      end
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        // Refill sets tag and the requested valid value
        if (wr_cl_vld_i && wr_cl_we_i[w]) begin
          tag_q[wr_cl_idx_i][w]   <= wr_cl_tag_i;
          valid_q[wr_cl_idx_i][w] <= wr_vld_bits_i[w];
        end
        // Word write marks the way valid, tag untouched
        // Comes last so it overrides a refill of the same way
        if (wr_req_i[w]) begin
          valid_q[wr_idx_i][w] <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  assign way_valid_o = valid_q[rd_idx_i];

  // Tag match qualified by valid
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit_o[w] = valid_q[rd_idx_i][w] && (tag_q[rd_idx_i][w] == rd_tag_i);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/victim_select.sv ====
`default_nettype none

module victim_select import dcache_pkg::*; #(
  parameter int unsigned  NUM_WAYS = DEF_NUM_WAYS,
  localparam int unsigned PTR_W    = $clog2(NUM_WAYS)
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Read strobe of the lookup port
  input  wire logic                rd_req_i,
  // Valid bits of the addressed set
  input  wire logic [NUM_WAYS-1:0] way_valid_i,
  // One-hot hit vector of the lookup
  input  wire logic [NUM_WAYS-1:0] way_hit_i,
  // One-hot way to refill
  output logic [NUM_WAYS-1:0]      victim_oh_o
);

  logic [PTR_W-1:0]    rr_ptr_q;
  logic [NUM_WAYS-1:0] inv_ways;
  logic [NUM_WAYS-1:0] first_inv;
  logic                set_full;
  logic                rr_step;

  ////////////////////////////////////////////////////////////
  // Victim choice
  ////////////////////////////////////////////////////////////

  assign inv_ways = ~way_valid_i;

  // Isolate the lowest set bit, lowest invalid way wins
  assign first_inv = inv_ways & (~inv_ways + 1'b1);

  assign set_full = &way_valid_i;

  // Fall back to the round-robin way only when the set is full
  assign victim_oh_o = set_full ? (NUM_WAYS'(1) << rr_ptr_q) : first_inv;

  ////////////////////////////////////////////////////////////
  // Round-robin pointer
  ////////////////////////////////////////////////////////////

  // Advance on a full-set miss
  assign rr_step = rd_req_i && set_full && !(|way_hit_i);

  // Wraps naturally since NUM_WAYS is a power of two
  // Flush leaves the pointer where it is
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else if (rr_step) begin
      rr_ptr_q <= rr_ptr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire
